// File: src/wb_params.svh
//--------------------------------------
// Wishbone fabric parameters
//--------------------------------------
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

// Data width and byte enables of one bus word
`define WB_ARCHBITSZ 32
`define WB_SELBITSZ 4

// Word address, byte address without the byte-offset bits
`define WB_ADDRBITSZ 30

// Number of slaves on the fabric
`define WB_SLAVECOUNT 3

// Byte address where the first slave window starts
`define WB_FIRST_ADDR 32'h0000_1000

// Slave that takes addresses outside every window
`define WB_DEFAULT_SLAVE 2

`endif

// File: src/wb_pkg.sv
//--------------------------------------
// Wishbone fabric types
//--------------------------------------
`include "wb_params.svh"

package wb_pkg;

	// Slave index, wide enough for every slave
	typedef logic [$clog2(`WB_SLAVECOUNT)-1:0] slv_idx_t;

	// Master to slave request
	typedef struct packed {
		logic                      cyc;
		logic                      stb;
		logic                      we;
		logic [`WB_ADDRBITSZ-1:0]  adr;
		logic [`WB_SELBITSZ-1:0]   sel;
		logic [`WB_ARCHBITSZ-1:0]  dat;
	} wb_req_t;

	// Slave to master response
	typedef struct packed {
		logic                      bsy;
		logic                      ack;
		logic [`WB_ARCHBITSZ-1:0]  dat;
	} wb_rsp_t;

	// Commands from the map FSM to the slot scanner
	typedef enum logic [1:0] {
		SCAN_HOLD,
		SCAN_STEP,
		SCAN_RESTART,
		SCAN_PARK
	} scan_cmd_t;

endpackage

// File: src/wb_map_fsm.sv
//--------------------------------------
// Address map sequencer
//--------------------------------------
`timescale 1ns/100ps

module wb_map_fsm (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic              hit_i,
	input  logic              last_i,
	input  logic              req_active_i,
	input  logic              is_default_i,
	output wb_pkg::scan_cmd_t scan_cmd_o,
	output logic              table_we_o,
	output logic              map_ready_o,
	output logic              lookup_bsy_o
);

	typedef enum logic [1:0] {
		ST_SETTLE,
		ST_BUILD,
		ST_LOCATE,
		ST_ROUTED
	} state_t;

	state_t state_q;
	state_t state_d;
	logic   map_ready_q;
	logic   map_ready_d;
	logic   miss;

	// Only an active request can leave its window
	assign miss = req_active_i && !hit_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= ST_SETTLE;
			map_ready_q <= 1'b0;
		end else begin
			state_q <= state_d;
			map_ready_q <= map_ready_d;
		end
	end

	always_comb begin
		state_d = state_q;
		map_ready_d = map_ready_q;
		scan_cmd_o = wb_pkg::SCAN_HOLD;
		table_we_o = 1'b0;

		case (state_q)
			// Table and size registers follow the new index here
			ST_SETTLE: begin
				state_d = map_ready_q ? ST_LOCATE : ST_BUILD;
			end

			// One table entry per slave, then rewind for the first lookup
			ST_BUILD: begin
				table_we_o = 1'b1;
				state_d = ST_SETTLE;
				if (last_i) begin
					scan_cmd_o = wb_pkg::SCAN_RESTART;
					map_ready_d = 1'b1;
				end else begin
					scan_cmd_o = wb_pkg::SCAN_STEP;
				end
			end

			ST_LOCATE: begin
				if (!miss) begin
					state_d = ST_ROUTED;
				end else begin
					state_d = ST_SETTLE;
					if (is_default_i)
						scan_cmd_o = wb_pkg::SCAN_RESTART;
					else if (last_i)
						scan_cmd_o = wb_pkg::SCAN_PARK;
					else
						scan_cmd_o = wb_pkg::SCAN_STEP;
				end
			end

			// Address left the window, search again from slave 0
			ST_ROUTED: begin
				if (miss) begin
					scan_cmd_o = wb_pkg::SCAN_RESTART;
					state_d = ST_SETTLE;
				end
			end

			default: begin
				state_d = ST_SETTLE;
			end
		endcase
	end

	assign map_ready_o = map_ready_q;

	// Busy rises in the same cycle as a miss
	assign lookup_bsy_o = (state_q != ST_ROUTED) || miss;

endmodule

// File: src/wb_slot_scan.sv
//--------------------------------------
// Slave slot scanner
//--------------------------------------
`timescale 1ns/100ps
`include "wb_params.svh"

module wb_slot_scan (
	input  logic                     clk_i,
	input  logic                     rst_i,
	input  wb_pkg::scan_cmd_t        scan_cmd_i,
	input  logic                     map_ready_i,
	input  logic [`WB_ARCHBITSZ-1:0] step_size_i,
	input  logic [`WB_ARCHBITSZ-1:0] park_addr_i,
	output wb_pkg::slv_idx_t         idx_o,
	output logic [`WB_ARCHBITSZ-1:0] lo_o,
	output logic                     last_o,
	output logic                     is_default_o
);

	localparam wb_pkg::slv_idx_t LAST_IDX = wb_pkg::slv_idx_t'(`WB_SLAVECOUNT - 1);
	localparam wb_pkg::slv_idx_t DEF_IDX = wb_pkg::slv_idx_t'(`WB_DEFAULT_SLAVE);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			idx_o <= '0;
			lo_o <= `WB_FIRST_ADDR;
			is_default_o <= 1'b0;
		end else begin
			case (scan_cmd_i)
				wb_pkg::SCAN_STEP: begin
					idx_o <= idx_o + 1'b1;
					is_default_o <= 1'b0;
					// Build stacks by size, lookup starts past the previous high bound
					if (map_ready_i)
						lo_o <= step_size_i + 1'b1;
					else
						lo_o <= lo_o + step_size_i;
				end
				wb_pkg::SCAN_RESTART: begin
					idx_o <= '0;
					lo_o <= `WB_FIRST_ADDR;
					is_default_o <= 1'b0;
				end
				// Unmapped address becomes offset zero of the default slave
				wb_pkg::SCAN_PARK: begin
					idx_o <= DEF_IDX;
					lo_o <= park_addr_i;
					is_default_o <= 1'b1;
				end
				default: begin
				end
			endcase
		end
	end

	assign last_o = (idx_o == LAST_IDX);

endmodule

// File: src/wb_ram_slave.sv
//--------------------------------------
// Wishbone word memory slave
//--------------------------------------
`timescale 1ns/100ps
`include "wb_params.svh"

module wb_ram_slave #(
	parameter int DEPTH_WORDS = 64
) (
	input  logic            clk_i,
	input  logic            rst_i,
	input  wb_pkg::wb_req_t req_i,
	output wb_pkg::wb_rsp_t rsp_o
);

	// Power-of-two depth, so the low address bits wrap the offset
	localparam int IDXW = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;
	localparam int BW = `WB_ARCHBITSZ / `WB_SELBITSZ;

	logic [`WB_ARCHBITSZ-1:0] mem [DEPTH_WORDS];
	logic [`WB_ARCHBITSZ-1:0] rdat_q;
	logic [IDXW-1:0]          widx;
	logic                     ack_q;
	logic                     accept;

	assign widx = req_i.adr[IDXW-1:0];

	// A strobe held across its own acknowledge is not taken twice
	assign accept = req_i.cyc && req_i.stb && !ack_q;

	always_ff @(posedge clk_i) begin
		if (rst_i)
			ack_q <= 1'b0;
		else
			ack_q <= accept;
	end

	// Byte-enabled write, registered read
	always_ff @(posedge clk_i) begin
		if (accept) begin
			if (req_i.we) begin
				for (int b = 0; b < `WB_SELBITSZ; b++) begin
					if (req_i.sel[b])
						mem[widx][b*BW +: BW] <= req_i.dat[b*BW +: BW];
				end
			end else begin
				rdat_q <= mem[widx];
			end
		end
	end

	// Never busy, acknowledge one cycle after the strobe
	assign rsp_o = '{bsy: 1'b0, ack: ack_q, dat: rdat_q};

endmodule

// File: src/wb_mux.sv
//--------------------------------------
// Wishbone address-map interconnect
//--------------------------------------
`timescale 1ns/100ps
`include "wb_params.svh"

module wb_mux (
	input  logic                     clk_i,
	input  logic                     rst_i,
	input  wb_pkg::wb_req_t          m_req_i,
	output wb_pkg::wb_rsp_t          m_rsp_o,
	output wb_pkg::wb_req_t          s_req_o [`WB_SLAVECOUNT],
	input  wb_pkg::wb_rsp_t          s_rsp_i [`WB_SLAVECOUNT],
	input  logic [`WB_ARCHBITSZ-1:0] mapsz_i [`WB_SLAVECOUNT]
);

	localparam int OFFW = $clog2(`WB_SELBITSZ);

	// Inclusive high byte address of each window
	logic [`WB_ARCHBITSZ-1:0] hi_tbl [`WB_SLAVECOUNT];
	logic [`WB_ARCHBITSZ-1:0] hi_q;
	logic [`WB_ARCHBITSZ-1:0] mapsz_q;
	logic [`WB_ARCHBITSZ-1:0] lo;
	logic [`WB_ARCHBITSZ-1:0] byte_addr;
	logic [`WB_ARCHBITSZ-1:0] step_size;
	logic [OFFW-1:0]          byte_off;
	logic [`WB_ADDRBITSZ-1:0] rebased_adr;
	wb_pkg::slv_idx_t         idx;
	wb_pkg::scan_cmd_t        scan_cmd;
	logic                     table_we;
	logic                     map_ready;
	logic                     lookup_bsy;
	logic                     hit;
	logic                     last;
	logic                     is_default;
	logic                     req_active;

	// Lowest enabled byte gives the byte offset
	always_comb begin
		byte_off = '0;
		for (int b = `WB_SELBITSZ - 1; b >= 0; b--) begin
			if (m_req_i.sel[b])
				byte_off = OFFW'(b);
		end
	end

	assign byte_addr = {m_req_i.adr, byte_off};
	assign req_active = m_req_i.cyc && m_req_i.stb;

	// A parked lookup matches only the address it parked on
	assign hit = is_default ? (byte_addr == lo) : ((byte_addr >= lo) && (byte_addr <= hi_q));

	assign rebased_adr = m_req_i.adr - lo[`WB_ARCHBITSZ-1:OFFW];
	assign step_size = map_ready ? hi_q : mapsz_q;

	always_ff @(posedge clk_i) begin
		hi_q <= hi_tbl[idx];
		if (!map_ready)
			mapsz_q <= mapsz_i[idx];
		if (table_we)
			hi_tbl[idx] <= lo + mapsz_q - 1'b1;
	end

	wb_map_fsm u_fsm (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.hit_i        (hit),
		.last_i       (last),
		.req_active_i (req_active),
		.is_default_i (is_default),
		.scan_cmd_o   (scan_cmd),
		.table_we_o   (table_we),
		.map_ready_o  (map_ready),
		.lookup_bsy_o (lookup_bsy)
	);

	wb_slot_scan u_scan (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.scan_cmd_i   (scan_cmd),
		.map_ready_i  (map_ready),
		.step_size_i  (step_size),
		.park_addr_i  (byte_addr),
		.idx_o        (idx),
		.lo_o         (lo),
		.last_o       (last),
		.is_default_o (is_default)
	);

	for (genvar i = 0; i < `WB_SLAVECOUNT; i++) begin : g_slv
		logic route;

		assign route = (idx == wb_pkg::slv_idx_t'(i)) && !lookup_bsy;

		always_comb begin
			s_req_o[i] = m_req_i;
			s_req_o[i].adr = rebased_adr;
			s_req_o[i].cyc = route && m_req_i.cyc;
			s_req_o[i].stb = route && m_req_i.stb;
		end
	end

	// Response from the selected slave, held off while a lookup runs
	always_comb begin
		m_rsp_o.bsy = lookup_bsy || s_rsp_i[idx].bsy;
		m_rsp_o.ack = !lookup_bsy && s_rsp_i[idx].ack;
		m_rsp_o.dat = s_rsp_i[idx].dat;
	end

endmodule

// File: src/wb_subsys_top.sv
//--------------------------------------
// Wishbone memory subsystem
//--------------------------------------
`timescale 1ns/100ps
`include "wb_params.svh"

module wb_subsys_top (
	input  logic                     clk_i,
	input  logic                     rst_i,
	input  wb_pkg::wb_req_t          m_req_i,
	output wb_pkg::wb_rsp_t          m_rsp_o,
	input  logic [`WB_ARCHBITSZ-1:0] mapsz_i [`WB_SLAVECOUNT]
);

	wb_pkg::wb_req_t s_req [`WB_SLAVECOUNT];
	wb_pkg::wb_rsp_t s_rsp [`WB_SLAVECOUNT];

	wb_mux u_mux (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.m_req_i (m_req_i),
		.m_rsp_o (m_rsp_o),
		.s_req_o (s_req),
		.s_rsp_i (s_rsp),
		.mapsz_i (mapsz_i)
	);

	wb_ram_slave #(.DEPTH_WORDS(64)) u_ram0 (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.req_i (s_req[0]),
		.rsp_o (s_rsp[0])
	);

	wb_ram_slave #(.DEPTH_WORDS(64)) u_ram1 (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.req_i (s_req[1]),
		.rsp_o (s_rsp[1])
	);

	// Smaller memory, also the default slave
	wb_ram_slave #(.DEPTH_WORDS(16)) u_ram2 (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.req_i (s_req[2]),
		.rsp_o (s_rsp[2])
	);

endmodule

// File: verif/tb_clkgen.sv
//--------------------------------------
// Testbench clock and reset
//--------------------------------------
`timescale 1ns/100ps

module tb_clkgen #(
	parameter int PERIOD_NS = 4,
	parameter int RST_CYCLES = 16
) (
	input  logic rst_req_i,
	output logic clk_o,
	output logic rst_o
);

	int rst_cnt = 0;

	initial begin
		clk_o = 1'b0;
		rst_o = 1'b1;
		forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
	end

	// A request restarts the reset pulse
	always @(posedge clk_o) begin
		if (rst_req_i) begin
			rst_o <= 1'b1;
			rst_cnt <= 0;
		end else if (rst_o) begin
			if (rst_cnt == RST_CYCLES - 1)
				rst_o <= 1'b0;
			rst_cnt <= rst_cnt + 1;
		end
	end

endmodule

// File: verif/wb_mux_properties.sv
//--------------------------------------
// Interconnect assertions
//--------------------------------------
`timescale 1ns/100ps
`include "wb_params.svh"

module wb_mux_properties (
	input logic            clk_i,
	input logic            rst_i,
	input logic            map_ready_i,
	input wb_pkg::wb_rsp_t m_rsp_i,
	input wb_pkg::wb_req_t s_req_i [`WB_SLAVECOUNT]
);

	int fail_cnt = 0;
	logic [`WB_SLAVECOUNT-1:0] s_cyc;

	always_comb begin
		for (int i = 0; i < `WB_SLAVECOUNT; i++)
			s_cyc[i] = s_req_i[i].cyc;
	end

	// Reset is synchronous, so the fabric is idle from the cycle after
	a_reset_idle: assert property (@(posedge clk_i) rst_i |=> (m_rsp_i.bsy && s_cyc == '0))
	else begin
		$error("Fabric not busy or a slave selected during reset");
		fail_cnt++;
	end

	a_build_idle: assert property (@(posedge clk_i)
		(!rst_i && !map_ready_i) |-> (m_rsp_i.bsy && s_cyc == '0))
	else begin
		$error("Fabric not busy or a slave selected while the map is built");
		fail_cnt++;
	end

	a_one_slave: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(s_cyc))
	else begin
		$error("More than one slave cycle active");
		fail_cnt++;
	end

	a_ack_not_busy: assert property (@(posedge clk_i) disable iff (rst_i)
		!(m_rsp_i.ack && m_rsp_i.bsy))
	else begin
		$error("Acknowledge reached the master while busy");
		fail_cnt++;
	end

endmodule

bind wb_mux wb_mux_properties u_props (
	.clk_i       (clk_i),
	.rst_i       (rst_i),
	.map_ready_i (map_ready),
	.m_rsp_i     (m_rsp_o),
	.s_req_i     (s_req_o)
);

// File: verif/wb_subsys_tb.sv
//--------------------------------------
// Wishbone subsystem testbench
//--------------------------------------
`timescale 1ns/100ps
`include "wb_params.svh"

module wb_subsys_tb;

	localparam int N = `WB_SLAVECOUNT;
	localparam int CLK_NS = 4;
	localparam int ACCESS_CYCLES = 24;
	localparam int READY_CYCLES = 40;
	// Fill, random, partial, unmapped, re-read, boundary and second random round
	localparam int NUM_ACCESSES = 144 + 48 + 24 + 12 + 56 + 16 + 24;
	localparam int SETUP_CYCLES = 2 * (16 + READY_CYCLES + 4);
	localparam int WATCHDOG_NS = (NUM_ACCESSES * ACCESS_CYCLES + SETUP_CYCLES) * CLK_NS;
	localparam int DEPTHS [N] = '{64, 64, 16};
	localparam logic [31:0] SIZES_A [N] = '{32'h100, 32'h100, 32'h40};
	localparam logic [31:0] SIZES_B [N] = '{32'h40, 32'h80, 32'h20};

	logic            clk;
	logic            rst;
	logic            rst_req;
	wb_pkg::wb_req_t m_req;
	wb_pkg::wb_rsp_t m_rsp;
	logic [31:0]     mapsz [N];
	logic [31:0]     win_lo [N];
	logic [31:0]     win_hi [N];
	logic [31:0]     model [N][64];
	int              data_errs = 0;
	int              timeout_errs = 0;
	int              prop_errs;

	tb_clkgen #(.PERIOD_NS(CLK_NS), .RST_CYCLES(16)) u_clkgen (
		.rst_req_i (rst_req),
		.clk_o     (clk),
		.rst_o     (rst)
	);

	wb_subsys_top UUT (
		.clk_i   (clk),
		.rst_i   (rst),
		.m_req_i (m_req),
		.m_rsp_o (m_rsp),
		.mapsz_i (mapsz)
	);

	// Windows stack upward from the first address in slave order
	function automatic void compute_windows();
		logic [31:0] base;
		base = `WB_FIRST_ADDR;
		for (int i = 0; i < N; i++) begin
			win_lo[i] = base;
			win_hi[i] = base + mapsz[i] - 1;
			base = base + mapsz[i];
		end
	endfunction

	// Slave and word that an address reaches, unmapped goes to default offset zero
	function automatic void resolve_slot(input logic [31:0] addr, output int slv, output int idx);
		slv = `WB_DEFAULT_SLAVE;
		idx = 0;
		for (int i = 0; i < N; i++) begin
			if (addr >= win_lo[i] && addr <= win_hi[i]) begin
				slv = i;
				idx = ((addr - win_lo[i]) >> 2) % DEPTHS[i];
			end
		end
	endfunction

	function automatic logic [31:0] fill_pattern(input logic [31:0] addr);
		return {addr[15:0] ^ 16'hC3A5, ~addr[15:0]} ^ {addr[31:16], addr[31:16]};
	endfunction

	task automatic bus_access(input logic we, input logic [31:0] addr, input logic [3:0] sel,
			input logic [31:0] wdat, output logic [31:0] rdat);
		int cycles;
		cycles = 0;
		@(posedge clk);
		m_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: addr[31:2], sel: sel, dat: wdat};
		@(negedge clk);
		while (!(m_rsp.ack && !m_rsp.bsy) && cycles < ACCESS_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		assert (cycles < ACCESS_CYCLES) else begin
			$display("Access to %h not acknowledged within %0d cycles", addr, ACCESS_CYCLES);
			timeout_errs++;
		end
		rdat = m_rsp.dat;
		@(posedge clk);
		m_req <= '0;
	endtask

	task automatic write_word(input logic [31:0] addr, input logic [3:0] sel,
			input logic [31:0] data);
		logic [31:0] unused;
		int slv;
		int idx;
		bus_access(1'b1, addr, sel, data, unused);
		resolve_slot(addr, slv, idx);
		for (int b = 0; b < 4; b++) begin
			if (sel[b])
				model[slv][idx][b*8 +: 8] = data[b*8 +: 8];
		end
	endtask

	task automatic check_read(input logic [31:0] addr);
		logic [31:0] rdat;
		int slv;
		int idx;
		bus_access(1'b0, addr, 4'hF, '0, rdat);
		resolve_slot(addr, slv, idx);
		assert (rdat === model[slv][idx]) else begin
			$display("Mismatch m_rsp_o.dat at %h: expected %h, got %h",
				addr, model[slv][idx], rdat);
			data_errs++;
		end
	endtask

	task automatic wait_ready();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (rst)
			@(negedge clk);
		while (m_rsp.bsy && cycles < READY_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		assert (!m_rsp.bsy) else begin
			$display("Address map not ready %0d cycles after reset", READY_CYCLES);
			timeout_errs++;
		end
		compute_windows();
	endtask

	task automatic restart_map(input logic [31:0] sizes [N]);
		@(posedge clk);
		mapsz <= sizes;
		rst_req <= 1'b1;
		@(posedge clk);
		rst_req <= 1'b0;
		wait_ready();
	endtask

	task automatic random_round(input int count);
		logic [31:0] addrs [$];
		logic [31:0] addr;
		int s;
		for (int k = 0; k < count; k++) begin
			s = $urandom_range(N - 1);
			addr = win_lo[s] + 4 * $urandom_range((win_hi[s] - win_lo[s]) >> 2);
			write_word(addr, 4'hF, $urandom);
			addrs.push_back(addr);
		end
		foreach (addrs[k])
			check_read(addrs[k]);
	endtask

	task automatic partial_round(input int count);
		logic [31:0] addr;
		logic [3:0] sel;
		int s;
		for (int k = 0; k < count; k++) begin
			s = $urandom_range(N - 1);
			addr = win_lo[s] + 4 * $urandom_range((win_hi[s] - win_lo[s]) >> 2);
			sel = 4'($urandom_range(14, 1));
			write_word(addr, sel, $urandom);
			check_read(addr);
		end
	endtask

	// Below the first window, then past the last one
	task automatic unmapped_round();
		logic [31:0] addr;
		for (int k = 0; k < 4; k++) begin
			if (k < 2)
				addr = 4 * $urandom_range((`WB_FIRST_ADDR >> 2) - 1);
			else
				addr = win_hi[N - 1] + 1 + 4 * $urandom_range(1023);
			write_word(addr, 4'hF, $urandom);
			check_read(win_lo[`WB_DEFAULT_SLAVE]);
			check_read(addr);
		end
	endtask

	task automatic boundary_round();
		for (int s = 0; s < N; s++) begin
			write_word(win_lo[s], 4'hF, $urandom);
			write_word(win_hi[s] - 3, 4'hF, $urandom);
			check_read(win_lo[s]);
			check_read(win_hi[s] - 3);
		end
		write_word(`WB_FIRST_ADDR - 4, 4'hF, $urandom);
		check_read(win_lo[`WB_DEFAULT_SLAVE]);
		write_word(win_hi[N - 1] + 1, 4'hF, $urandom);
		check_read(win_lo[`WB_DEFAULT_SLAVE]);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Run did not finish within %0d ns", WATCHDOG_NS);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		logic [31:0] addr;
		void'($urandom(84770));
		m_req = '0;
		rst_req = 1'b0;
		mapsz = SIZES_A;
		wait_ready();

		// Every word of every window gets an address-dependent value
		for (int s = 0; s < N; s++) begin
			for (addr = win_lo[s]; addr <= win_hi[s]; addr += 4)
				write_word(addr, 4'hF, fill_pattern(addr));
		end
		random_round(24);
		partial_round(12);
		unmapped_round();

		// New sizes move the windows, memories keep their contents
		restart_map(SIZES_B);
		for (int s = 0; s < N; s++) begin
			for (addr = win_lo[s]; addr <= win_hi[s]; addr += 4)
				check_read(addr);
		end
		boundary_round();
		random_round(12);

		prop_errs = UUT.u_mux.u_props.fail_cnt;
		$display("Errors: data %0d, timeout %0d, assertion %0d",
			data_errs, timeout_errs, prop_errs);
		if (data_errs + timeout_errs + prop_errs == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+src
src/wb_pkg.sv
src/wb_map_fsm.sv
src/wb_slot_scan.sv
src/wb_ram_slave.sv
src/wb_mux.sv
src/wb_subsys_top.sv
verif/tb_clkgen.sv
verif/wb_mux_properties.sv
verif/wb_subsys_tb.sv
